/* hw/feistel_pkg.sv */
// feistel cipher shared constants

package feistel_pkg;

    // one half block, also the width of every box entry
    localparam int word_w = 32;

    // rounds of the feistel network
    localparam int default_rounds = 16;

    // entries per s-box, indexed by one byte of the left half
    localparam int sbox_entries = 256;

    // apb address bus
    localparam int apb_addr_w = 16;

    // p-array region, one word every 4 bytes
    localparam logic [apb_addr_w-1:0] p_base = 16'h0000;

    // s-box region, box b entry i at s_base + 4 * (b * 256 + i)
    localparam logic [apb_addr_w-1:0] s_base = 16'h1000;

    // first byte address past the s-boxes
    localparam logic [apb_addr_w-1:0] addr_limit = 16'h2000;

endpackage

/* hw/key_box_regs.sv */
// key box register file
`timescale 1ns/1ps

module key_box_regs #(
    parameter int ROUNDS = feistel_pkg::default_rounds
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // apb slave
    input  logic [feistel_pkg::apb_addr_w-1:0]   paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [feistel_pkg::word_w-1:0]       pwdata,
    output logic [feistel_pkg::word_w-1:0]       prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    // lookup indices from the pipeline
    input  logic [$clog2(ROUNDS+2)-1:0]          p_idx_a,
    input  logic [$clog2(ROUNDS+2)-1:0]          p_idx_b,
    input  logic [$clog2(ROUNDS+2)-1:0]          p_idx_c,
    input  logic [$clog2(ROUNDS+2)-1:0]          p_idx_d,
    input  logic [7:0]                           s_byte0,
    input  logic [7:0]                           s_byte1,
    input  logic [7:0]                           s_byte2,
    input  logic [7:0]                           s_byte3,
    // lookup results, same cycle
    output logic [feistel_pkg::word_w-1:0]       p_word_a,
    output logic [feistel_pkg::word_w-1:0]       p_word_b,
    output logic [feistel_pkg::word_w-1:0]       p_word_c,
    output logic [feistel_pkg::word_w-1:0]       p_word_d,
    output logic [feistel_pkg::word_w-1:0]       s_word0,
    output logic [feistel_pkg::word_w-1:0]       s_word1,
    output logic [feistel_pkg::word_w-1:0]       s_word2,
    output logic [feistel_pkg::word_w-1:0]       s_word3
);

    localparam int AW      = feistel_pkg::apb_addr_w;
    localparam int WW      = feistel_pkg::word_w;
    localparam int P_WORDS = ROUNDS + 2;
    localparam int P_IDX_W = $clog2(P_WORDS);
    localparam int S_IDX_W = $clog2(feistel_pkg::sbox_entries);
    localparam logic [AW-1:0] P_SPAN = AW'(4 * P_WORDS);

    logic [WW-1:0] p_arr [P_WORDS];
    logic [WW-1:0] s_mem [4][feistel_pkg::sbox_entries];

    logic [AW-1:0]      p_off;
    logic [AW-1:0]      s_off;
    logic               aligned;
    logic               in_p;
    logic               in_s;
    logic               addr_ok;
    logic [P_IDX_W-1:0] p_sel;
    logic [1:0]         s_box_sel;
    logic [S_IDX_W-1:0] s_ent_sel;
    logic [WW-1:0]      rd_word;
    logic               setup;
    logic               wr_en;

    // no wait states
    assign pready = 1'b1;

    // address decode
    assign p_off     = paddr - feistel_pkg::p_base;
    assign s_off     = paddr - feistel_pkg::s_base;
    assign aligned   = (paddr[1:0] == 2'b00);
    assign in_p      = (p_off < P_SPAN);
    assign in_s      = (paddr >= feistel_pkg::s_base) && (paddr < feistel_pkg::addr_limit);
    assign addr_ok   = aligned && (in_p || in_s);
    assign p_sel     = p_off[P_IDX_W+1:2];
    assign s_ent_sel = s_off[S_IDX_W+1:2];
    assign s_box_sel = s_off[S_IDX_W+3:S_IDX_W+2];

    assign setup = psel && !penable;
    assign wr_en = psel && penable && pwrite && addr_ok;

    // only meaningful when addr_ok
    assign rd_word = in_p ? p_arr[p_sel] : s_mem[s_box_sel][s_ent_sel];

    // error flag captured in setup, shown during the access phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pslverr <= 1'b0;
        end else begin
            pslverr <= setup && !addr_ok;
        end
    end

    // read data the same way, zero for bad addresses and writes
    always_ff @(posedge clk) begin
        if (setup && !pwrite && addr_ok) begin
            prdata <= rd_word;
        end else begin
            prdata <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && in_p) begin
            p_arr[p_sel] <= pwdata;
        end
        if (wr_en && !in_p) begin
            s_mem[s_box_sel][s_ent_sel] <= pwdata;
        end
    end

    // pipeline lookups
    assign p_word_a = p_arr[p_idx_a];
    assign p_word_b = p_arr[p_idx_b];
    assign p_word_c = p_arr[p_idx_c];
    assign p_word_d = p_arr[p_idx_d];

    assign s_word0 = s_mem[0][s_byte0];
    assign s_word1 = s_mem[1][s_byte1];
    assign s_word2 = s_mem[2][s_byte2];
    assign s_word3 = s_mem[3][s_byte3];

endmodule

/* hw/whiten_stage.sv */
// input whitening stage
`timescale 1ns/1ps

module whiten_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  logic [feistel_pkg::word_w-1:0] in_l,
    input  logic [feistel_pkg::word_w-1:0] in_r,
    output logic                           in_ready,
    input  logic [feistel_pkg::word_w-1:0] p_first,
    output logic                           st_valid,
    output logic [feistel_pkg::word_w-1:0] st_l,
    output logic [feistel_pkg::word_w-1:0] st_r,
    input  logic                           st_ready
);

    logic run;
    logic take;

    // ready once out of reset, and the slot is free or draining now
    assign in_ready = run && (!st_valid || st_ready);
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run      <= 1'b0;
            st_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (take) begin
                st_valid <= 1'b1;
            end else if (st_ready) begin
                st_valid <= 1'b0;
            end
        end
    end

    // left half gets P[0], right half passes as is
    always_ff @(posedge clk) begin
        if (take) begin
            st_l <= in_l ^ p_first;
            st_r <= in_r;
        end
    end

endmodule

/* hw/round_engine.sv */
// iterative feistel round unit
`timescale 1ns/1ps

module round_engine #(
    parameter int ROUNDS = feistel_pkg::default_rounds
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           st_valid,
    input  logic [feistel_pkg::word_w-1:0] st_l,
    input  logic [feistel_pkg::word_w-1:0] st_r,
    output logic                           st_ready,
    output logic [$clog2(ROUNDS+2)-1:0]    p_idx,
    input  logic [feistel_pkg::word_w-1:0] p_round,
    output logic [7:0]                     s_byte0,
    output logic [7:0]                     s_byte1,
    output logic [7:0]                     s_byte2,
    output logic [7:0]                     s_byte3,
    input  logic [feistel_pkg::word_w-1:0] s_word0,
    input  logic [feistel_pkg::word_w-1:0] s_word1,
    input  logic [feistel_pkg::word_w-1:0] s_word2,
    input  logic [feistel_pkg::word_w-1:0] s_word3,
    output logic                           rd_valid,
    output logic [feistel_pkg::word_w-1:0] rd_l,
    output logic [feistel_pkg::word_w-1:0] rd_r,
    input  logic                           rd_ready
);

    localparam int WW      = feistel_pkg::word_w;
    localparam int P_IDX_W = $clog2(ROUNDS + 2);
    localparam logic [P_IDX_W-1:0] LAST = P_IDX_W'(ROUNDS);

    logic [WW-1:0]      l_q;
    logic [WW-1:0]      r_q;
    logic [WW-1:0]      f_out;
    // round about to run, zero when not iterating
    logic [P_IDX_W-1:0] round;
    logic               running;
    logic               load;
    logic               hand_off;

    assign running  = (round != '0);
    assign hand_off = rd_valid && rd_ready;

    // free when idle, or when the held result leaves this cycle
    assign st_ready = !running && (!rd_valid || rd_ready);
    assign load     = st_valid && st_ready;

    // P word for the current round
    assign p_idx = round;

    // one s-box lookup per byte of the left half, msb first
    assign s_byte0 = l_q[31:24];
    assign s_byte1 = l_q[23:16];
    assign s_byte2 = l_q[15:8];
    assign s_byte3 = l_q[7:0];

    // F function, adds wrap at 32 bits
    assign f_out = ((s_word0 + s_word1) ^ s_word2) + s_word3;

    assign rd_l = l_q;
    assign rd_r = r_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            round    <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (load) begin
                round    <= P_IDX_W'(1);
                rd_valid <= 1'b0;
            end else if (running) begin
                if (round == LAST) begin
                    // last round done, hold until finish stage takes it
                    round    <= '0;
                    rd_valid <= 1'b1;
                end else begin
                    round <= round + 1'b1;
                end
            end else if (hand_off) begin
                rd_valid <= 1'b0;
            end
        end
    end

    // (L, R) -> (R ^ F(L) ^ P[r], L)
    always_ff @(posedge clk) begin
        if (load) begin
            l_q <= st_l;
            r_q <= st_r;
        end else if (running) begin
            l_q <= r_q ^ f_out ^ p_round;
            r_q <= l_q;
        end
    end

endmodule

/* hw/finish_stage.sv */
// final swap and output whitening
`timescale 1ns/1ps

module finish_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           rd_valid,
    input  logic [feistel_pkg::word_w-1:0] rd_l,
    input  logic [feistel_pkg::word_w-1:0] rd_r,
    output logic                           rd_ready,
    // P[ROUNDS+1] and P[ROUNDS]
    input  logic [feistel_pkg::word_w-1:0] p_last,
    input  logic [feistel_pkg::word_w-1:0] p_prev,
    output logic                           out_valid,
    output logic [feistel_pkg::word_w-1:0] out_l,
    output logic [feistel_pkg::word_w-1:0] out_r,
    input  logic                           out_ready
);

    logic take;

    // room when empty or when the held block leaves now
    assign rd_ready = !out_valid || out_ready;
    assign take     = rd_valid && rd_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            if (take) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // undo the last round's swap while whitening
    always_ff @(posedge clk) begin
        if (take) begin
            out_l <= rd_r ^ p_last;
            out_r <= rd_l ^ p_prev;
        end
    end

endmodule

/* hw/feistel_cipher_top.sv */
// feistel cipher top level
`timescale 1ns/1ps

module feistel_cipher_top #(
    parameter int ROUNDS = feistel_pkg::default_rounds
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [feistel_pkg::apb_addr_w-1:0] paddr,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [feistel_pkg::word_w-1:0]     pwdata,
    output logic [feistel_pkg::word_w-1:0]     prdata,
    output logic                               pready,
    output logic                               pslverr,
    input  logic                               in_valid,
    input  logic [feistel_pkg::word_w-1:0]     in_l,
    input  logic [feistel_pkg::word_w-1:0]     in_r,
    output logic                               in_ready,
    output logic                               out_valid,
    output logic [feistel_pkg::word_w-1:0]     out_l,
    output logic [feistel_pkg::word_w-1:0]     out_r,
    input  logic                               out_ready
);

    localparam int WW      = feistel_pkg::word_w;
    localparam int P_IDX_W = $clog2(ROUNDS + 2);

    // fixed P indices for whitening
    localparam logic [P_IDX_W-1:0] IDX_FIRST = '0;
    localparam logic [P_IDX_W-1:0] IDX_PREV  = P_IDX_W'(ROUNDS);
    localparam logic [P_IDX_W-1:0] IDX_LAST  = P_IDX_W'(ROUNDS + 1);

    logic [WW-1:0]      p_first;
    logic [WW-1:0]      p_round;
    logic [WW-1:0]      p_prev;
    logic [WW-1:0]      p_last;
    logic [P_IDX_W-1:0] p_idx;
    logic [7:0]         s_byte0;
    logic [7:0]         s_byte1;
    logic [7:0]         s_byte2;
    logic [7:0]         s_byte3;
    logic [WW-1:0]      s_word0;
    logic [WW-1:0]      s_word1;
    logic [WW-1:0]      s_word2;
    logic [WW-1:0]      s_word3;

    logic               st_valid;
    logic               st_ready;
    logic [WW-1:0]      st_l;
    logic [WW-1:0]      st_r;
    logic               rd_valid;
    logic               rd_ready;
    logic [WW-1:0]      rd_l;
    logic [WW-1:0]      rd_r;

    key_box_regs #(
        .ROUNDS(ROUNDS)
    ) i_key_box_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .p_idx_a (IDX_FIRST),
        .p_idx_b (p_idx),
        .p_idx_c (IDX_PREV),
        .p_idx_d (IDX_LAST),
        .s_byte0 (s_byte0),
        .s_byte1 (s_byte1),
        .s_byte2 (s_byte2),
        .s_byte3 (s_byte3),
        .p_word_a(p_first),
        .p_word_b(p_round),
        .p_word_c(p_prev),
        .p_word_d(p_last),
        .s_word0 (s_word0),
        .s_word1 (s_word1),
        .s_word2 (s_word2),
        .s_word3 (s_word3)
    );

    whiten_stage i_whiten_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_valid(in_valid),
        .in_l    (in_l),
        .in_r    (in_r),
        .in_ready(in_ready),
        .p_first (p_first),
        .st_valid(st_valid),
        .st_l    (st_l),
        .st_r    (st_r),
        .st_ready(st_ready)
    );

    round_engine #(
        .ROUNDS(ROUNDS)
    ) i_round_engine (
        .clk     (clk),
        .rst_n   (rst_n),
        .st_valid(st_valid),
        .st_l    (st_l),
        .st_r    (st_r),
        .st_ready(st_ready),
        .p_idx   (p_idx),
        .p_round (p_round),
        .s_byte0 (s_byte0),
        .s_byte1 (s_byte1),
        .s_byte2 (s_byte2),
        .s_byte3 (s_byte3),
        .s_word0 (s_word0),
        .s_word1 (s_word1),
        .s_word2 (s_word2),
        .s_word3 (s_word3),
        .rd_valid(rd_valid),
        .rd_l    (rd_l),
        .rd_r    (rd_r),
        .rd_ready(rd_ready)
    );

    finish_stage i_finish_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_valid (rd_valid),
        .rd_l     (rd_l),
        .rd_r     (rd_r),
        .rd_ready (rd_ready),
        .p_last   (p_last),
        .p_prev   (p_prev),
        .out_valid(out_valid),
        .out_l    (out_l),
        .out_r    (out_r),
        .out_ready(out_ready)
    );

endmodule

/* verif/feistel_cipher_assertions.sv */
// cipher handshake and apb checks
`timescale 1ns/1ps

module feistel_cipher_assertions (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           psel,
    input logic                           penable,
    input logic                           pready,
    input logic                           in_valid,
    input logic                           in_ready,
    input logic [feistel_pkg::word_w-1:0] in_l,
    input logic [feistel_pkg::word_w-1:0] in_r,
    input logic                           out_valid,
    input logic                           out_ready,
    input logic [feistel_pkg::word_w-1:0] out_l,
    input logic [feistel_pkg::word_w-1:0] out_r
);

    // read back by the testbench at the end of the run
    int fail_count = 0;

    // a stalled output block keeps its value
    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_l) && $stable(out_r)))
    else begin
        $error("output block changed while out_ready was low");
        fail_count = fail_count + 1;
    end

    // offered plaintext stays until taken
    in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_l) && $stable(in_r)))
    else begin
        $error("input block dropped or changed before acceptance");
        fail_count = fail_count + 1;
    end

    // zero wait states
    no_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable) |-> pready)
    else begin
        $error("pready low in an apb access phase");
        fail_count = fail_count + 1;
    end

endmodule

bind feistel_cipher_top feistel_cipher_assertions i_feistel_cipher_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .psel     (psel),
    .penable  (penable),
    .pready   (pready),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_l     (in_l),
    .in_r     (in_r),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_l    (out_l),
    .out_r    (out_r)
);

/* verif/feistel_cipher_tb.sv */
// feistel cipher testbench
`timescale 1ns/1ps

module feistel_cipher_tb;

    localparam int ROUNDS     = feistel_pkg::default_rounds;
    localparam int P_WORDS    = ROUNDS + 2;
    localparam int AW         = feistel_pkg::apb_addr_w;
    localparam int NUM_ROWS   = 8;
    localparam int CLK_PERIOD = 100;
    localparam int QUARTER    = CLK_PERIOD / 4;
    // each apb access takes three cycles, well under two full loads in total
    localparam int APB_CYCLES = 3 * 2 * (P_WORDS + 4 * feistel_pkg::sbox_entries);
    localparam int BP_FACTOR  = 4;
    localparam int WATCHDOG_CYCLES = APB_CYCLES + 3 * NUM_ROWS * (ROUNDS + 2) * BP_FACTOR + 500;

    localparam logic [63:0] PLAIN_TAB [NUM_ROWS] = '{
        64'h0000_0000_0000_0000, 64'hffff_ffff_ffff_ffff,
        64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210,
        64'h0000_0001_0000_0000, 64'h8000_0000_0000_0001,
        64'hdead_beef_cafe_f00d, 64'h5a5a_a5a5_3c3c_c3c3
    };
    // unaligned, gap and out of range
    localparam logic [AW-1:0] BAD_ADDR [6] = '{
        16'h0005, 16'h181e, 16'h0048, 16'h0ffc, 16'h2000, 16'hfffc
    };

    logic          clk;
    logic          rst_n;
    logic [AW-1:0] paddr;
    logic          psel;
    logic          penable;
    logic          pwrite;
    logic [31:0]   pwdata;
    logic [31:0]   prdata;
    logic          pready;
    logic          pslverr;
    logic          in_valid;
    logic [31:0]   in_l;
    logic [31:0]   in_r;
    logic          in_ready;
    logic          out_valid;
    logic [31:0]   out_l;
    logic [31:0]   out_r;
    logic          out_ready;

    logic [31:0] lfsr = 32'h476f_f50c;
    logic [31:0] p_model [P_WORDS];
    logic [31:0] s_model [4][feistel_pkg::sbox_entries];
    logic [31:0] exp_l [NUM_ROWS];
    logic [31:0] exp_r [NUM_ROWS];
    logic [31:0] prev_l [NUM_ROWS];
    logic [31:0] prev_r [NUM_ROWS];
    int          cycle_cnt = 0;
    int          accept_cycle;
    int          first_valid_cycle;

    feistel_cipher_top #(
        .ROUNDS(ROUNDS)
    ) i_feistel_cipher_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .in_valid (in_valid),
        .in_l     (in_l),
        .in_r     (in_r),
        .in_ready (in_ready),
        .out_valid(out_valid),
        .out_l    (out_l),
        .out_r    (out_r),
        .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s expected 0x%08h got 0x%08h", name, exp, got));
        end
    endtask

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [AW-1:0] p_addr(input int idx);
        return feistel_pkg::p_base + AW'(4 * idx);
    endfunction

    function automatic logic [AW-1:0] s_addr(input int box, input int ent);
        return feistel_pkg::s_base + AW'(4 * (box * feistel_pkg::sbox_entries + ent));
    endfunction

    // reference cipher on the testbench copy of the boxes
    function automatic logic [63:0] model_encrypt(input logic [63:0] blk);
        logic [31:0] l;
        logic [31:0] r;
        logic [31:0] f;
        logic [31:0] t;
        l = blk[63:32] ^ p_model[0];
        r = blk[31:0];
        for (int k = 1; k <= ROUNDS; k++) begin
            f = ((s_model[0][l[31:24]] + s_model[1][l[23:16]]) ^ s_model[2][l[15:8]])
                + s_model[3][l[7:0]];
            t = r ^ f ^ p_model[k];
            r = l;
            l = t;
        end
        return {r ^ p_model[ROUNDS + 1], l ^ p_model[ROUNDS]};
    endfunction

    // setup, access, idle; response checked in the access phase
    task automatic apb_access(input logic wr, input logic [AW-1:0] addr, input logic [31:0] wdata,
                              input logic [31:0] exp_rdata, input logic exp_err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        check_value("pready", 32'd1, 32'(pready));
        check_value($sformatf("pslverr@%04h", addr), 32'(exp_err), 32'(pslverr));
        if (!wr) begin
            check_value($sformatf("prdata@%04h", addr), exp_rdata, prdata);
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_p(input int idx, input logic [31:0] data);
        apb_access(1'b1, p_addr(idx), data, '0, 1'b0);
        p_model[idx] = data;
    endtask

    task automatic write_s(input int box, input int ent, input logic [31:0] data);
        apb_access(1'b1, s_addr(box, ent), data, '0, 1'b0);
        s_model[box][ent] = data;
    endtask

    task automatic fill_expected();
        for (int i = 0; i < NUM_ROWS; i++) begin
            {exp_l[i], exp_r[i]} = model_encrypt(PLAIN_TAB[i]);
        end
    endtask

    task automatic send_blocks();
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_l     = PLAIN_TAB[i][63:32];
            in_r     = PLAIN_TAB[i][31:0];
            #(QUARTER);
            while (!in_ready) begin
                @(negedge clk);
                #(QUARTER);
            end
            // transfer happens on the coming rising edge
            if (i == 0) begin
                accept_cycle = cycle_cnt + 1;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic receive_blocks(input bit use_bp);
        int idx;
        bit seen;
        idx  = 0;
        seen = 1'b0;
        while (idx < NUM_ROWS) begin
            @(negedge clk);
            out_ready = use_bp ? (random_bits(1) != 0) : 1'b1;
            #(QUARTER);
            if (out_valid && !seen) begin
                first_valid_cycle = cycle_cnt;
                seen = 1'b1;
            end
            if (out_valid && out_ready) begin
                check_value($sformatf("out_l[%0d]", idx), exp_l[idx], out_l);
                check_value($sformatf("out_r[%0d]", idx), exp_r[idx], out_r);
                idx++;
            end
        end
    endtask

    task automatic run_burst(input bit use_bp);
        fork
            send_blocks();
            receive_blocks(use_bp);
        join
        @(negedge clk);
        out_ready = 1'b1;
        if (!use_bp) begin
            check_value("latency", 32'(ROUNDS + 2), 32'(first_valid_cycle - accept_cycle));
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        logic [31:0] rnd;
        rst_n     = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        in_valid  = 1'b0;
        in_l      = '0;
        in_r      = '0;
        out_ready = 1'b0;
        repeat (2) @(negedge clk);
        // handshakes and error flag idle while reset is held
        check_value("in_ready", 32'd0, 32'(in_ready));
        check_value("out_valid", 32'd0, 32'(out_valid));
        check_value("pslverr", 32'd0, 32'(pslverr));
        rst_n = 1'b1;

        // full key load, then readback of all P words and sampled S entries
        for (int i = 0; i < P_WORDS; i++) begin
            write_p(i, random_bits(32));
        end
        for (int b = 0; b < 4; b++) begin
            for (int e = 0; e < feistel_pkg::sbox_entries; e++) begin
                write_s(b, e, random_bits(32));
            end
        end
        for (int i = 0; i < P_WORDS; i++) begin
            apb_access(1'b0, p_addr(i), '0, p_model[i], 1'b0);
        end
        repeat (32) begin
            rnd = random_bits(10);
            apb_access(1'b0, s_addr(rnd[9:8], rnd[7:0]), '0, s_model[rnd[9:8]][rnd[7:0]], 1'b0);
        end

        // bad addresses flag an error, read zero and write nothing
        for (int i = 0; i < 6; i++) begin
            apb_access(1'b1, BAD_ADDR[i], random_bits(32), '0, 1'b1);
            apb_access(1'b0, BAD_ADDR[i], '0, '0, 1'b1);
        end
        // words these addresses would alias onto
        apb_access(1'b0, p_addr(1), '0, p_model[1], 1'b0);
        apb_access(1'b0, s_addr(2, 7), '0, s_model[2][7], 1'b0);
        apb_access(1'b0, s_addr(3, 255), '0, s_model[3][255], 1'b0);
        apb_access(1'b0, s_addr(0, 0), '0, s_model[0][0], 1'b0);

        fill_expected();
        run_burst(1'b0);
        run_burst(1'b1);

        // rekey between bursts
        for (int i = 0; i < NUM_ROWS; i++) begin
            prev_l[i] = exp_l[i];
            prev_r[i] = exp_r[i];
        end
        write_p(5, random_bits(32));
        write_s(1, 8'h5a, random_bits(32));
        fill_expected();
        for (int i = 0; i < NUM_ROWS; i++) begin
            if ({exp_l[i], exp_r[i]} == {prev_l[i], prev_r[i]}) begin
                abort_run($sformatf("rekey left the ciphertext of row %0d unchanged", i));
            end
        end
        run_burst(1'b0);

        if (i_feistel_cipher_top.i_feistel_cipher_assertions.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run("concurrent assertions failed during the run");
        end
    end

endmodule

/* feistel_cipher_top.f */
hw/feistel_pkg.sv
hw/key_box_regs.sv
hw/whiten_stage.sv
hw/round_engine.sv
hw/finish_stage.sv
hw/feistel_cipher_top.sv
verif/feistel_cipher_assertions.sv
verif/feistel_cipher_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := feistel_cipher_tb
FILELIST  := feistel_cipher_top.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(SIM_BIN) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
